// ==== hdl/dac_pkg.sv ====
// shared types for the dac command path: command words, axi4-lite structs, fsm states, address map
`default_nettype none

package dac_pkg;

    // --------------------
    // dac command words
    // --------------------
    typedef enum logic [3:0] {
        DAC_CMD_WRU = 4'h3,   // write and update
        DAC_CMD_NOP = 4'hF    // no operation
    } dac_cmd_e;

    // 32-bit word as shifted into one ltc2601-style dac
    typedef struct packed {
        logic [7:0]  rsvd_hi; // don't care bits, sent as zero
        dac_cmd_e    cmd;
        logic [3:0]  rsvd_lo; // address nibble, unused
        logic [15:0] val;     // setpoint, offset binary
    } dac_word_t;

    // nop at mid scale, the idle state of every channel
    localparam dac_word_t DAC_NOP_WORD = '{
        rsvd_hi: 8'h00,
        cmd:     DAC_CMD_NOP,
        rsvd_lo: 4'h0,
        val:     16'h8000
    };

    // one channel write, valid for a single cycle
    typedef struct packed {
        logic        valid;
        logic [15:0] val;
    } chan_wr_t;

    // --------------------
    // axi4-lite
    // --------------------
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // master to slave
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_e  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_e  rresp;
    } axil_rsp_t;

    // --------------------
    // fsm states
    // --------------------
    typedef enum logic [1:0] {WR_IDLE, WR_ACK, WR_EXEC, WR_RESP} wr_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_ACK, RD_DATA} rd_state_e;
    typedef enum logic [1:0] {SPI_IDLE, SPI_LOAD, SPI_SHIFT, SPI_DONE} spi_state_e;

    // address map
    localparam logic [7:0] ADDR_CTRL   = 8'h00; // trigger on write, status on read
    localparam logic [7:0] CHAN_STRIDE = 8'h10; // channel c at c * stride

endpackage

`default_nettype wire

// ==== hdl/dac_channel.sv ====
// dac_channel: live command word and readback copy of one dac, with nop flush
`timescale 1ns/1ns
`default_nettype none

module dac_channel import dac_pkg::*; (
    input  wire           sysclk,
    input  wire           rst_n,
    input  wire chan_wr_t wr,    // one-cycle write from the front end
    input  wire           flush, // word was just loaded by the serializer
    output dac_word_t     word,  // live word, shifted out next frame
    output dac_word_t     copy   // last real command
);

    dac_word_t wru_word;

    // write and update command around the new value
    always_comb begin
        wru_word         = DAC_NOP_WORD;
        wru_word.rsvd_hi = 8'h00;
        wru_word.cmd     = DAC_CMD_WRU;
        wru_word.rsvd_lo = 4'h0;
        wru_word.val     = wr.val;
    end

    // --------------------
    // live word
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            word <= DAC_NOP_WORD;
        end else if (flush) begin
            word <= DAC_NOP_WORD; // flush beats a write
        end else if (wr.valid) begin
            word <= wru_word;
        end
    end

    // --------------------
    // readback copy
    // --------------------
    // never flushed, so the host and dac_val see the
    // most recent command even after it was sent
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            copy <= DAC_NOP_WORD;
        end else if (wr.valid) begin
            copy <= wru_word;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dac_cmd_front.sv ====
// dac_cmd_front: axi4-lite slave, address decode, busy rejection, val_ready edge and trigger
`timescale 1ns/1ns
`default_nettype none

module dac_cmd_front import dac_pkg::*; #(
    parameter int NUM_CHAN = 4
) (
    input  wire                          sysclk,
    input  wire                          rst_n,
    input  wire axil_req_t               axil_req,
    output axil_rsp_t                    axil_rsp,
    input  wire                          dig_cur_ctrl, // 1: digital current control
    input  wire [NUM_CHAN-1:0][15:0]     cont_val,     // controller voltage words
    input  wire                          val_ready,
    input  wire                          busy,         // frame in progress
    input  wire dac_word_t [NUM_CHAN-1:0] rd_word,     // readback copies
    output chan_wr_t [NUM_CHAN-1:0]      chan_wr,
    output logic                         trig
);

    localparam int IDX_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

    wr_state_e   wr_state;
    rd_state_e   rd_state;
    axil_resp_e  bresp_q;
    axil_resp_e  rresp_q;
    logic [31:0] rdata_q;
    logic        val_ready_q;  // previous val_ready
    logic        trig_req;     // data stored this cycle, fire next

    logic        wr_accept;    // aw and w handshake on this edge
    logic        wr_full;      // all four strobes set
    logic        aw_ctrl;
    logic        aw_chan;
    logic        host_load;
    logic        host_trig;
    logic        dig_load;
    logic        ar_ctrl;
    logic        ar_chan;

    // channel c (from 1) decodes at c * stride, offset zero
    function automatic logic is_chan(input logic [7:0] addr);
        logic [7:0] slot;
        slot = addr / CHAN_STRIDE;
        return (addr % CHAN_STRIDE == 8'd0) && (slot != 8'd0) && (slot <= NUM_CHAN);
    endfunction

    function automatic logic [IDX_W-1:0] chan_idx(input logic [7:0] addr);
        logic [7:0] slot;
        slot = addr / CHAN_STRIDE - 8'd1; // zero based
        return slot[IDX_W-1:0];
    endfunction

    // --------------------
    // decode
    // --------------------
    assign wr_accept = (wr_state == WR_ACK);
    assign wr_full   = (axil_req.wstrb == 4'hF); // partial strobes have no effect
    assign aw_ctrl   = (axil_req.awaddr == ADDR_CTRL);
    assign aw_chan   = is_chan(axil_req.awaddr);
    assign ar_ctrl   = (axil_req.araddr == ADDR_CTRL);
    assign ar_chan   = is_chan(axil_req.araddr);

    assign host_trig = wr_accept && aw_ctrl && !busy && wr_full;
    assign host_load = wr_accept && aw_chan && !busy && wr_full && !dig_cur_ctrl;
    assign dig_load  = dig_cur_ctrl && val_ready && !val_ready_q && !busy; // rising edge

    // --------------------
    // write channel
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            bresp_q  <= RESP_OKAY;
        end else begin
            case (wr_state)
                WR_IDLE: if (axil_req.awvalid && axil_req.wvalid) wr_state <= WR_ACK;
                WR_ACK: begin
                    wr_state <= WR_EXEC; // data lands in the channel next edge
                    if (busy || !(aw_ctrl || aw_chan))
                        bresp_q <= RESP_SLVERR;
                    else
                        bresp_q <= RESP_OKAY; // digital mode drops host writes silently
                end
                WR_EXEC: wr_state <= WR_RESP;
                WR_RESP: if (axil_req.bready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // --------------------
    // read channel
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
            rresp_q  <= RESP_OKAY;
            rdata_q  <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: if (axil_req.arvalid) rd_state <= RD_ACK;
                RD_ACK: begin
                    rd_state <= RD_DATA;
                    rresp_q  <= (ar_ctrl || ar_chan) ? RESP_OKAY : RESP_SLVERR;
                    if (ar_ctrl)
                        rdata_q <= {30'd0, dig_cur_ctrl, busy}; // status word
                    else if (ar_chan)
                        rdata_q <= rd_word[chan_idx(axil_req.araddr)];
                    else
                        rdata_q <= '0;
                end
                RD_DATA: if (axil_req.rready) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // --------------------
    // channel writes and trigger
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            chan_wr     <= '0;
            val_ready_q <= 1'b0;
            trig_req    <= 1'b0;
            trig        <= 1'b0;
        end else begin
            val_ready_q <= val_ready;
            trig_req    <= host_trig || dig_load;
            trig        <= trig_req; // one cycle after the words are stored
            for (int c = 0; c < NUM_CHAN; c++) begin
                chan_wr[c].valid <= dig_load; // all channels at once
                chan_wr[c].val   <= cont_val[c];
            end
            if (host_load) begin
                chan_wr[chan_idx(axil_req.awaddr)] <= '{valid: 1'b1, val: axil_req.wdata[15:0]};
            end
        end
    end

    // response struct, built from state
    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;     // paired with awready
        axil_rsp.bvalid  = (wr_state == WR_RESP);
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = (rd_state == RD_ACK);
        axil_rsp.rvalid  = (rd_state == RD_DATA);
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

endmodule

`default_nettype wire

// ==== hdl/dac_spi_chain.sv ====
// dac_spi_chain: spi serializer for a daisy chain of dacs, with per-channel flush
`timescale 1ns/1ns
`default_nettype none

module dac_spi_chain import dac_pkg::*; #(
    parameter int NUM_CHAN = 4,
    parameter int SCLK_DIV = 2
) (
    input  wire                           sysclk,
    input  wire                           rst_n,
    input  wire                           trig,  // start one frame
    input  wire dac_word_t [NUM_CHAN-1:0] words, // live words of all channels
    output logic                          sclk,
    output logic                          mosi,
    output logic                          csel,  // active low
    output logic                          busy,
    output logic [NUM_CHAN-1:0]           flush  // one-hot, on word load
);

    localparam int IDX_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;
    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam logic [IDX_W-1:0] TOP_CHAN = IDX_W'(NUM_CHAN - 1);

    spi_state_e       state;
    logic [DIV_W-1:0] div_cnt;  // sysclk cycles within a half period
    logic [4:0]       bit_cnt;  // bit within the current word
    logic [IDX_W-1:0] chan;     // counts down, last dac in chain goes first
    logic [31:0]      shreg;
    logic             half_end; // sclk toggles on this edge
    logic             bit_end;  // falling sclk, bit done

    assign half_end = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign bit_end  = half_end && sclk;

    assign csel = (state == SPI_IDLE);
    assign busy = (state != SPI_IDLE); // same edges as csel
    assign mosi = shreg[31];           // msb first

    // --------------------
    // frame fsm
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state   <= SPI_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            chan    <= TOP_CHAN;
            shreg   <= '0;
            sclk    <= 1'b0;
            flush   <= '0;
        end else begin
            flush <= '0; // pulse only
            case (state)
                SPI_IDLE: begin
                    if (trig) begin
                        state   <= SPI_LOAD; // csel drops here
                        chan    <= TOP_CHAN;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                SPI_LOAD: begin
                    shreg <= words[chan];
                    flush <= NUM_CHAN'(1) << chan;
                    state <= SPI_SHIFT;
                end
                SPI_SHIFT: begin
                    div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                    if (half_end) sclk <= ~sclk;
                    if (bit_end) begin
                        // next bit goes out as sclk falls
                        if (bit_cnt == 5'd31) begin
                            bit_cnt <= '0;
                            if (chan == '0) begin
                                state <= SPI_DONE; // whole chain sent
                                shreg <= '0;
                            end else begin
                                chan  <= chan - 1'b1;
                                shreg <= words[chan - 1'b1]; // no gap between words
                                flush <= NUM_CHAN'(1) << (chan - 1'b1);
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            shreg   <= {shreg[30:0], 1'b0};
                        end
                    end
                end
                SPI_DONE: state <= SPI_IDLE; // csel rises, dacs latch
                default:  state <= SPI_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dac_ctrl_top.sv ====
// dac_ctrl_top: axi4-lite front end, channel registers and spi chain serializer
`timescale 1ns/1ns
`default_nettype none

module dac_ctrl_top import dac_pkg::*; #(
    parameter int NUM_CHAN = 4, // dacs in the daisy chain
    parameter int SCLK_DIV = 2  // sysclk cycles per sclk half period
) (
    input  wire                      sysclk,
    input  wire                      rst_n,
    // host bus
    input  wire axil_req_t           axil_req,
    output axil_rsp_t                axil_rsp,
    // digital current control
    input  wire                      dig_cur_ctrl,
    input  wire [NUM_CHAN-1:0][15:0] cont_val,
    input  wire                      val_ready,
    // spi to the dac chain
    output logic                     sclk,
    output logic                     mosi,
    output logic                     csel,
    // readback values
    output logic [NUM_CHAN-1:0][15:0] dac_val
);

    chan_wr_t  [NUM_CHAN-1:0] chan_wr;
    dac_word_t [NUM_CHAN-1:0] live_word; // into the serializer
    dac_word_t [NUM_CHAN-1:0] copy_word; // readback
    logic      [NUM_CHAN-1:0] flush;
    logic                     trig;
    logic                     busy;

    dac_cmd_front #(
        .NUM_CHAN (NUM_CHAN)
    ) dac_cmd_front_i (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .dig_cur_ctrl (dig_cur_ctrl),
        .cont_val     (cont_val),
        .val_ready    (val_ready),
        .busy         (busy),
        .rd_word      (copy_word),
        .chan_wr      (chan_wr),
        .trig         (trig)
    );

    // --------------------
    // channel registers
    // --------------------
    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        dac_channel dac_channel_i (
            .sysclk (sysclk),
            .rst_n  (rst_n),
            .wr     (chan_wr[c]),
            .flush  (flush[c]),
            .word   (live_word[c]),
            .copy   (copy_word[c])
        );
        assign dac_val[c] = copy_word[c].val;
    end

    dac_spi_chain #(
        .NUM_CHAN (NUM_CHAN),
        .SCLK_DIV (SCLK_DIV)
    ) dac_spi_chain_i (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .trig   (trig),
        .words  (live_word),
        .sclk   (sclk),
        .mosi   (mosi),
        .csel   (csel),
        .busy   (busy),
        .flush  (flush)
    );

endmodule

`default_nettype wire

// ==== verification/dac_ctrl_chk.sv ====
// dac_ctrl_chk: bound assertions on axi4-lite response hold and spi pin behavior
`timescale 1ns/1ns
`default_nettype none

module dac_ctrl_chk import dac_pkg::*; (
    input wire            sysclk,
    input wire            rst_n,
    input wire axil_req_t axil_req,
    input wire axil_rsp_t axil_rsp,
    input wire            sclk,
    input wire            mosi,
    input wire            csel
);

    int fail_cnt = 0; // failed assertions so far

    // --------------------
    // axi4-lite
    // --------------------
    bvalid_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        $error("bvalid dropped before the master raised bready");
        fail_cnt++;
    end

    rvalid_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
        $error("rvalid dropped before the master raised rready");
        fail_cnt++;
    end

    // --------------------
    // spi pins
    // --------------------
    sclk_idle: assert property (@(posedge sysclk) disable iff (!rst_n)
        csel |-> !sclk) // clock parked low outside a frame
    else begin
        $error("sclk high while csel is deasserted");
        fail_cnt++;
    end

    // dacs sample on the rising edge, so data may only move while sclk is low
    mosi_stable: assert property (@(posedge sysclk) disable iff (!rst_n)
        sclk && $past(sclk) |-> mosi == $past(mosi))
    else begin
        $error("mosi changed while sclk was high");
        fail_cnt++;
    end

endmodule

bind dac_ctrl_top dac_ctrl_chk dac_ctrl_chk_i (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .sclk     (sclk),
    .mosi     (mosi),
    .csel     (csel)
);

`default_nettype wire

// ==== verification/dac_ctrl_tb.sv ====
// dac_ctrl_tb: clock, reset, axi4-lite tasks, spi capture, scenarios, watchdog and result
`timescale 1ns/1ns
`default_nettype none

module dac_ctrl_tb import dac_pkg::*; ();

    localparam int NUM_CHAN     = 4;
    localparam int SCLK_DIV     = 2;
    localparam int FRAME_CYC    = NUM_CHAN * 32 * 2 * SCLK_DIV + 2; // sysclk cycles per frame
    localparam int WATCHDOG_CYC = 20 * FRAME_CYC + 2000;
    localparam logic [31:0] NOP_WORD = 32'h00F0_8000; // nop, mid scale

    logic                      sysclk = 1'b0;
    logic                      rst_n;
    axil_req_t                 axil_req;
    axil_rsp_t                 axil_rsp;
    logic                      dig_cur_ctrl;
    logic [NUM_CHAN-1:0][15:0] cont_val;
    logic                      val_ready;
    logic                      sclk;
    logic                      mosi;
    logic                      csel;
    logic [NUM_CHAN-1:0][15:0] dac_val;

    logic [31:0]  exp_live [NUM_CHAN]; // model of the words sent next frame
    logic [31:0]  exp_copy [NUM_CHAN]; // model of the readback copies
    logic [127:0] cap_shift;
    logic [127:0] last_frame;
    int           cap_bits;
    int           last_bits;
    int           frames_seen = 0;
    int           errors = 0;
    integer       seed;

    always #10 sysclk = ~sysclk; // 20 ns period

    dac_ctrl_top #(
        .NUM_CHAN (NUM_CHAN),
        .SCLK_DIV (SCLK_DIV)
    ) dac_ctrl_top_i (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .dig_cur_ctrl (dig_cur_ctrl),
        .cont_val     (cont_val),
        .val_ready    (val_ready),
        .sclk         (sclk),
        .mosi         (mosi),
        .csel         (csel),
        .dac_val      (dac_val)
    );

    function automatic logic [31:0] wru_word(input logic [15:0] v);
        return {8'h00, 4'h3, 4'h0, v}; // write and update
    endfunction

    // highest channel leaves first
    function automatic logic [127:0] expected_frame();
        logic [127:0] f;
        f = '0;
        for (int c = NUM_CHAN - 1; c >= 0; c--) f = {f[95:0], exp_live[c]};
        return f;
    endfunction

    task automatic check_equal(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp)
        else begin
            $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    // --------------------
    // axi4-lite master
    // --------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(posedge sysclk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        do @(negedge sysclk); while (!(axil_rsp.awready && axil_rsp.wready));
        @(posedge sysclk);                 // handshake edge
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        do @(negedge sysclk); while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
        @(posedge sysclk);                 // bvalid waits one edge with bready low
        axil_req.bready <= 1'b1;
        @(posedge sysclk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge sysclk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        do @(negedge sysclk); while (!axil_rsp.arready);
        @(posedge sysclk);
        axil_req.arvalid <= 1'b0;
        do @(negedge sysclk); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge sysclk);                 // rvalid waits one edge with rready low
        axil_req.rready <= 1'b1;
        @(posedge sysclk);
        axil_req.rready <= 1'b0;
    endtask

    // every channel read and dac_val against the readback model
    task automatic check_readback();
        logic [31:0] data;
        logic [1:0]  resp;
        for (int c = 0; c < NUM_CHAN; c++) begin
            axil_read(8'(CHAN_STRIDE * (c + 1)), data, resp);
            check_equal("rresp", RESP_OKAY, resp);
            check_equal($sformatf("rdata ch%0d", c + 1), exp_copy[c], data);
            check_equal($sformatf("dac_val[%0d]", c), exp_copy[c][15:0], dac_val[c]);
        end
    endtask

    // --------------------
    // spi capture
    // --------------------
    initial begin
        forever begin
            @(negedge csel);
            cap_bits  = 0;
            cap_shift = '0;
            while (csel === 1'b0) begin
                @(posedge sclk or posedge csel);
                if (csel === 1'b0) begin
                    cap_shift = {cap_shift[126:0], mosi}; // msb arrives first
                    cap_bits++;
                end
            end
            last_frame = cap_shift;
            last_bits  = cap_bits;
            frames_seen++;
        end
    end

    task automatic wait_frame_end(input int seen_before);
        int n;
        n = 0;
        while (frames_seen == seen_before && n < 2 * FRAME_CYC + 20) begin
            @(negedge sysclk);
            n++;
        end
        if (frames_seen == seen_before) begin
            $display("No SPI frame ended within %0d cycles at %0t ns", n, $time);
            errors++;
        end
    endtask

    task automatic check_frame();
        check_equal("frame bits", 128'(NUM_CHAN * 32), 128'(last_bits));
        check_equal("spi frame", expected_frame(), last_frame);
        for (int c = 0; c < NUM_CHAN; c++) exp_live[c] = NOP_WORD; // flushed on load
    endtask

    // --------------------
    // scenarios
    // --------------------
    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        logic [15:0] v;
        int          seen;
        seed         = 32'hf212;
        rst_n        = 1'b0;
        axil_req     = '0;
        dig_cur_ctrl = 1'b0;
        cont_val     = '0;
        val_ready    = 1'b0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            exp_live[c] = NOP_WORD;
            exp_copy[c] = NOP_WORD;
        end
        repeat (4) @(posedge sysclk);
        rst_n <= 1'b1;
        @(negedge sysclk);

        // idle after reset
        check_equal("csel", 1'b1, csel);
        check_equal("sclk", 1'b0, sclk);
        check_readback();
        axil_read(ADDR_CTRL, data, resp);
        check_equal("busy", 1'b0, data[0]);

        // analog mode, one random setpoint per channel
        for (int c = 0; c < NUM_CHAN; c++) begin
            v = 16'($random(seed));
            axil_write(8'(CHAN_STRIDE * (c + 1)), {16'h0, v}, resp);
            check_equal("bresp", RESP_OKAY, resp);
            exp_live[c] = wru_word(v);
            exp_copy[c] = wru_word(v);
        end
        check_readback();

        // trigger, then a second one with nothing new (all nop)
        repeat (2) begin
            seen = frames_seen;
            axil_write(ADDR_CTRL, 32'h1, resp);
            check_equal("bresp", RESP_OKAY, resp);
            wait_frame_end(seen);
            check_frame();
            check_readback();
        end

        // only ch2 written, then host access during the frame
        v = 16'($random(seed));
        axil_write(8'(CHAN_STRIDE * 2), {16'h0, v}, resp);
        check_equal("bresp", RESP_OKAY, resp);
        exp_live[1] = wru_word(v);
        exp_copy[1] = wru_word(v);
        seen = frames_seen;
        axil_write(ADDR_CTRL, 32'h1, resp);
        check_equal("bresp", RESP_OKAY, resp);
        axil_write(8'(CHAN_STRIDE), 32'h0000_4321, resp); // rejected while busy
        check_equal("bresp busy", RESP_SLVERR, resp);
        axil_read(ADDR_CTRL, data, resp);
        check_equal("busy", 1'b1, data[0]);
        wait_frame_end(seen);
        check_frame();
        check_readback();

        // digital mode, words from the controller
        @(posedge sysclk);
        dig_cur_ctrl <= 1'b1;
        for (int c = 0; c < NUM_CHAN; c++) begin
            v = 16'($random(seed));
            cont_val[c] <= v;
            exp_live[c] = wru_word(v);
            exp_copy[c] = wru_word(v);
        end
        seen = frames_seen;
        @(posedge sysclk);
        val_ready <= 1'b1; // rising edge starts the frame
        wait_frame_end(seen);
        check_frame();
        @(posedge sysclk);
        val_ready <= 1'b0;
        check_readback();
        axil_read(ADDR_CTRL, data, resp);
        check_equal("dig_cur_ctrl", 1'b1, data[1]);
        axil_write(8'(CHAN_STRIDE * 3), 32'h0000_1234, resp); // dropped in this mode
        check_equal("bresp digital", RESP_OKAY, resp);
        check_readback();

        repeat (10) @(posedge sysclk);
        $display("errors: %0d testbench, %0d assertion", errors,
                 dac_ctrl_top_i.dac_ctrl_chk_i.fail_cnt);
        if (errors == 0 && dac_ctrl_top_i.dac_ctrl_chk_i.fail_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        repeat (WATCHDOG_CYC) @(posedge sysclk);
        $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYC);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/dac_pkg.sv
hdl/dac_channel.sv
hdl/dac_cmd_front.sv
hdl/dac_spi_chain.sv
hdl/dac_ctrl_top.sv
verification/dac_ctrl_chk.sv
verification/dac_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dac_ctrl testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dac_ctrl_tb \
    -f flist.f \
    --Mdir obj_dir -o dac_ctrl_sim

# assertion errors must not end the run before the result line
./obj_dir/dac_ctrl_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0
